/* Makefile */
# Verilator build and run of the stack core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= stack_core_tb
FILELIST  ?= stack_core.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/ctrl_pkg.sv */
/*
 * Control codes from the instruction decoder
 * to the fetch and execute units
 */
`default_nettype none

package ctrl_pkg;

	// ------------------------------------------------------------
	// ALU function
	// ------------------------------------------------------------
	localparam int alu_sel_bits = 3;
	// Pass hands operand B through untouched
	localparam logic [alu_sel_bits-1:0] alu_pass = 3'd0;
	localparam logic [alu_sel_bits-1:0] alu_add  = 3'd1;
	localparam logic [alu_sel_bits-1:0] alu_sub  = 3'd2;
	localparam logic [alu_sel_bits-1:0] alu_and  = 3'd3;
	localparam logic [alu_sel_bits-1:0] alu_orr  = 3'd4;
	localparam logic [alu_sel_bits-1:0] alu_xor  = 3'd5;

	// Source of operand B
	localparam int src_sel_bits = 2;
	localparam logic [src_sel_bits-1:0] src_mem = 2'd0;
	localparam logic [src_sel_bits-1:0] src_io  = 2'd1;
	localparam logic [src_sel_bits-1:0] src_acc = 2'd2;

	// Next program address
	localparam int br_sel_bits = 3;
	localparam logic [br_sel_bits-1:0] br_next = 3'd0;
	localparam logic [br_sel_bits-1:0] br_jump = 3'd1;
	localparam logic [br_sel_bits-1:0] br_zero = 3'd2;
	localparam logic [br_sel_bits-1:0] br_call = 3'd3;
	localparam logic [br_sel_bits-1:0] br_ret  = 3'd4;

endpackage

`default_nettype wire

/* design/exec_unit.sv */
/*
 * Execute unit
 * Operand selection, ALU, accumulator, data stack
 * and the registered output port
 */
`timescale 1ns/10ps
`default_nettype none

module exec_unit #(
	parameter int data_bits    = 16,
	parameter int dstack_depth = 8
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [ctrl_pkg::alu_sel_bits-1:0]  alu_sel,
	input  logic [ctrl_pkg::src_sel_bits-1:0]  src_sel,
	input  logic                              acc_load,
	input  logic                              push,
	input  logic                              pop,
	input  logic                              out_strobe,
	input  logic [isa_pkg::io_port_bits-1:0]   port,
	input  logic [data_bits-1:0]              mem_data_rd,
	input  logic [data_bits-1:0]              io_in,
	output logic                              acc_zero,
	output logic [data_bits-1:0]              mem_data_wr,
	output logic                              out_en,
	output logic [isa_pkg::io_port_bits-1:0]   out_port,
	output logic [data_bits-1:0]              out_data
);

	import ctrl_pkg::*;

	logic [data_bits-1:0] acc;
	logic [data_bits-1:0] stack_top;
	logic [data_bits-1:0] opnd_a;
	logic [data_bits-1:0] opnd_b;
	logic [data_bits-1:0] alu_out;

	// ------------------------------------------------------------
	// Data stack
	// ------------------------------------------------------------
	// Always saves the accumulator before it changes
	lifo_stack #(
		.width(data_bits),
		.depth(dstack_depth)
	) i_dstack (
		.clk (clk),
		.rst (rst),
		.push(push),
		.pop (pop),
		.din (acc),
		.top (stack_top)
	);

	// ------------------------------------------------------------
	// Operands and ALU
	// ------------------------------------------------------------
	// Stack forms put the popped word on side A
	assign opnd_a = pop ? stack_top : acc;

	always_comb begin
		case (src_sel)
			src_io:  opnd_b = io_in;
			src_acc: opnd_b = acc;
			default: opnd_b = mem_data_rd;
		endcase
	end

	// Wraps modulo 2**data_bits
	always_comb begin
		case (alu_sel)
			alu_add: alu_out = opnd_a + opnd_b;
			alu_sub: alu_out = opnd_a - opnd_b;
			alu_and: alu_out = opnd_a & opnd_b;
			alu_orr: alu_out = opnd_a | opnd_b;
			alu_xor: alu_out = opnd_a ^ opnd_b;
			default: alu_out = opnd_b;
		endcase
	end

	// Accumulator
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else if (acc_load) begin
			acc <= alu_out;
		end
	end

	assign acc_zero    = (acc == '0);
	// Store writes the current accumulator
	assign mem_data_wr = acc;

	// ------------------------------------------------------------
	// Output port
	// ------------------------------------------------------------
	// One-cycle strobe after the out instruction
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_en <= 1'b0;
		end else begin
			out_en <= out_strobe;
		end
	end

	// Port and value held until the next out
	always_ff @(posedge clk) begin
		if (out_strobe) begin
			out_port <= port;
			out_data <= acc;
		end
	end

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
/*
 * Instruction fetch
 * Program counter, next-address choice and return stack
 */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
	parameter int rstack_depth = 8
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [ctrl_pkg::br_sel_bits-1:0]  br_sel,
	input  logic [isa_pkg::code_addr_bits-1:0] target,
	input  logic                              acc_zero,
	output logic [isa_pkg::code_addr_bits-1:0] instr_addr
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	logic [code_addr_bits-1:0] pc;
	logic [code_addr_bits-1:0] pc_inc;
	logic [code_addr_bits-1:0] pc_next;
	logic [code_addr_bits-1:0] ret_addr;

	assign pc_inc = pc + 1'b1;

	// ------------------------------------------------------------
	// Return stack
	// ------------------------------------------------------------
	// Call saves the address after itself
	lifo_stack #(
		.width(code_addr_bits),
		.depth(rstack_depth)
	) i_rstack (
		.clk (clk),
		.rst (rst),
		.push(br_sel == br_call),
		.pop (br_sel == br_ret),
		.din (pc_inc),
		.top (ret_addr)
	);

	// ------------------------------------------------------------
	// Next address
	// ------------------------------------------------------------
	always_comb begin
		case (br_sel)
			br_jump: pc_next = target;
			br_call: pc_next = target;
			// Taken only on a zero accumulator
			br_zero: pc_next = acc_zero ? target : pc_inc;
			br_ret:  pc_next = ret_addr;
			default: pc_next = pc_inc;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	// Memory is addressed straight from the PC register
	assign instr_addr = pc;

endmodule

`default_nettype wire

/* design/instr_dec.sv */
/*
 * Instruction decoder
 * Combinational map from opcode to ALU, stack, memory,
 * I/O and branch controls
 */
`timescale 1ns/10ps
`default_nettype none

module instr_dec (
	input  isa_pkg::instr_t                  instr,
	output logic [ctrl_pkg::alu_sel_bits-1:0] alu_sel,
	output logic [ctrl_pkg::src_sel_bits-1:0] src_sel,
	output logic                             acc_load,
	output logic                             push,
	output logic                             pop,
	output logic                             mem_wr,
	output logic                             out_strobe,
	output logic [ctrl_pkg::br_sel_bits-1:0]  br_sel
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	always_comb begin
		// Idle set that unknown opcodes also take
		alu_sel    = alu_pass;
		src_sel    = src_mem;
		acc_load   = 1'b0;
		push       = 1'b0;
		pop        = 1'b0;
		mem_wr     = 1'b0;
		out_strobe = 1'b0;
		br_sel     = br_next;

		case (instr.opcode)
			// ------------------------------------------------------------
			// Load, store and push
			// ------------------------------------------------------------
			// Old acc goes to the stack, memory word replaces it
			op_lod: begin
				push     = 1'b1;
				acc_load = 1'b1;
			end
			op_set: mem_wr = 1'b1;
			op_psh: push = 1'b1;

			// ------------------------------------------------------------
			// ALU memory forms
			// ------------------------------------------------------------
			op_add, op_sub, op_and, op_orr, op_xor: begin
				acc_load = 1'b1;
				case (instr.opcode)
					op_add:  alu_sel = alu_add;
					op_sub:  alu_sel = alu_sub;
					op_and:  alu_sel = alu_and;
					op_orr:  alu_sel = alu_orr;
					default: alu_sel = alu_xor;
				endcase
			end

			// Stack forms take the stack top as operand A and acc as B
			op_add_p, op_sub_p, op_and_p, op_orr_p, op_xor_p: begin
				acc_load = 1'b1;
				pop      = 1'b1;
				src_sel  = src_acc;
				case (instr.opcode)
					op_add_p: alu_sel = alu_add;
					op_sub_p: alu_sel = alu_sub;
					op_and_p: alu_sel = alu_and;
					op_orr_p: alu_sel = alu_orr;
					default:  alu_sel = alu_xor;
				endcase
			end

			// ------------------------------------------------------------
			// Flow control
			// ------------------------------------------------------------
			op_jmp: br_sel = br_jump;
			op_jiz: br_sel = br_zero;
			op_cal: br_sel = br_call;
			op_ret: br_sel = br_ret;

			// Input behaves like a load from the port
			op_inn: begin
				push     = 1'b1;
				acc_load = 1'b1;
				src_sel  = src_io;
			end
			op_out: out_strobe = 1'b1;

			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* design/isa_pkg.sv */
/*
 * Instruction set of the stack core
 * One 16-bit word per instruction with opcode over operand
 */
`default_nettype none

package isa_pkg;

	// Field widths
	localparam int opcode_bits    = 7;
	localparam int operand_bits   = 9;
	localparam int instr_bits     = opcode_bits + operand_bits;
	localparam int code_addr_bits = 9;
	localparam int data_addr_bits = 9;
	localparam int io_port_bits   = 3;

	// ------------------------------------------------------------
	// Opcodes (anything not listed executes as a nop)
	// ------------------------------------------------------------
	localparam logic [opcode_bits-1:0] op_nop   = 7'd0;
	localparam logic [opcode_bits-1:0] op_lod   = 7'd1;
	localparam logic [opcode_bits-1:0] op_set   = 7'd2;
	// Memory forms compute acc op mem
	localparam logic [opcode_bits-1:0] op_add   = 7'd3;
	localparam logic [opcode_bits-1:0] op_sub   = 7'd4;
	localparam logic [opcode_bits-1:0] op_and   = 7'd5;
	localparam logic [opcode_bits-1:0] op_orr   = 7'd6;
	localparam logic [opcode_bits-1:0] op_xor   = 7'd7;
	// Stack forms compute pop op acc
	localparam logic [opcode_bits-1:0] op_add_p = 7'd8;
	localparam logic [opcode_bits-1:0] op_sub_p = 7'd9;
	localparam logic [opcode_bits-1:0] op_and_p = 7'd10;
	localparam logic [opcode_bits-1:0] op_orr_p = 7'd11;
	localparam logic [opcode_bits-1:0] op_xor_p = 7'd12;
	// Flow control
	localparam logic [opcode_bits-1:0] op_jmp   = 7'd13;
	localparam logic [opcode_bits-1:0] op_jiz   = 7'd14;
	localparam logic [opcode_bits-1:0] op_cal   = 7'd15;
	localparam logic [opcode_bits-1:0] op_ret   = 7'd16;
	// I/O and push
	localparam logic [opcode_bits-1:0] op_inn   = 7'd17;
	localparam logic [opcode_bits-1:0] op_out   = 7'd18;
	localparam logic [opcode_bits-1:0] op_psh   = 7'd19;

	// Operand seen as code address or as I/O port number
	typedef union packed {
		logic [code_addr_bits-1:0] target;
		struct packed {
			logic [operand_bits-io_port_bits-1:0] spare;
			logic [io_port_bits-1:0]              port;
		} io;
	} operand_u;

	typedef struct packed {
		logic [opcode_bits-1:0] opcode;
		operand_u               operand;
	} instr_t;

endpackage

`default_nettype wire

/* design/lifo_stack.sv */
/*
 * Last-in first-out store with a single pointer
 * Serves as return stack and as data stack
 */
`timescale 1ns/10ps
`default_nettype none

module lifo_stack #(
	parameter int width = 16,
	parameter int depth = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic             pop,
	input  logic [width-1:0] din,
	output logic [width-1:0] top
);

	// At least one pointer bit even for a single entry
	localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;

	logic [width-1:0]    mem [depth];
	logic [ptr_bits-1:0] ptr;

	// Pointer marks the next free slot
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr + 1'b1;
		end else if (pop) begin
			ptr <= ptr - 1'b1;
		end
	end

	// Write into the free slot
	always_ff @(posedge clk) begin
		if (push) begin
			mem[ptr] <= din;
		end
	end

	// Newest entry sits just below the pointer
	assign top = mem[ptr - 1'b1];

endmodule

`default_nettype wire

/* design/stack_core.sv */
/*
 * Stack-accumulator processor core
 * Single-cycle fetch, decode and execute on external memories
 */
`timescale 1ns/10ps
`default_nettype none

module stack_core #(
	parameter int data_bits    = 16,
	parameter int rstack_depth = 8,
	parameter int dstack_depth = 8
) (
	input  logic                               clk,
	input  logic                               rst,
	input  isa_pkg::instr_t                    instr,
	output logic [isa_pkg::code_addr_bits-1:0] instr_addr,
	output logic [isa_pkg::data_addr_bits-1:0] mem_addr,
	input  logic [data_bits-1:0]               mem_data_rd,
	output logic                               mem_wr,
	output logic [data_bits-1:0]               mem_data_wr,
	input  logic [data_bits-1:0]               io_in,
	output logic [isa_pkg::io_port_bits-1:0]   in_port,
	output logic                               out_en,
	output logic [isa_pkg::io_port_bits-1:0]   out_port,
	output logic [data_bits-1:0]               out_data
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	// Decoder controls
	logic [alu_sel_bits-1:0] alu_sel;
	logic [src_sel_bits-1:0] src_sel;
	logic [br_sel_bits-1:0]  br_sel;
	logic                    acc_load;
	logic                    push;
	logic                    pop;
	logic                    out_strobe;
	logic                    acc_zero;

	// ------------------------------------------------------------
	// Operand views
	// ------------------------------------------------------------
	// Data address shares the bits of the code target
	assign mem_addr = instr.operand.target[data_addr_bits-1:0];
	assign in_port  = instr.operand.io.port;

	fetch_unit #(
		.rstack_depth(rstack_depth)
	) i_fetch_unit (
		.clk       (clk),
		.rst       (rst),
		.br_sel    (br_sel),
		.target    (instr.operand.target),
		.acc_zero  (acc_zero),
		.instr_addr(instr_addr)
	);

	instr_dec i_instr_dec (
		.instr     (instr),
		.alu_sel   (alu_sel),
		.src_sel   (src_sel),
		.acc_load  (acc_load),
		.push      (push),
		.pop       (pop),
		.mem_wr    (mem_wr),
		.out_strobe(out_strobe),
		.br_sel    (br_sel)
	);

	exec_unit #(
		.data_bits   (data_bits),
		.dstack_depth(dstack_depth)
	) i_exec_unit (
		.clk        (clk),
		.rst        (rst),
		.alu_sel    (alu_sel),
		.src_sel    (src_sel),
		.acc_load   (acc_load),
		.push       (push),
		.pop        (pop),
		.out_strobe (out_strobe),
		.port       (instr.operand.io.port),
		.mem_data_rd(mem_data_rd),
		.io_in      (io_in),
		.acc_zero   (acc_zero),
		.mem_data_wr(mem_data_wr),
		.out_en     (out_en),
		.out_port   (out_port),
		.out_data   (out_data)
	);

endmodule

`default_nettype wire

/* stack_core.f */
+incdir+testbench
design/isa_pkg.sv
design/ctrl_pkg.sv
design/lifo_stack.sv
design/fetch_unit.sv
design/instr_dec.sv
design/exec_unit.sv
design/stack_core.sv
testbench/stack_core_tb.sv

/* testbench/stack_core_tb_ref.svh */
/*
 * Test program and reference interpreter for the stack core
 * Expected outputs follow from the instruction rules alone
 */
`ifndef STACK_CORE_TB_REF_SVH
`define STACK_CORE_TB_REF_SVH

// Section starts name each expected output
localparam int sec_stack  = 16;
localparam int sec_store  = 32;
localparam int sec_loop   = 37;
localparam int sec_call   = 43;
localparam int prog_len   = 55;
localparam int halt_addr  = 54;
localparam int step_limit = 5000;

// Countdown constants placed over the random fill
localparam logic [data_addr_bits-1:0] one_addr   = 9'h1F0;
localparam logic [data_addr_bits-1:0] count_addr = 9'h1F1;
localparam logic [data_bits-1:0]      count_init = 16'd4;

localparam logic [instr_bits-1:0] program_image [prog_len] = '{
	// Memory forms and input at 0..15
	{op_lod, 9'h010}, {op_out, 9'd1}, {op_add, 9'h011}, {op_out, 9'd2},
	{op_sub, 9'h012}, {op_out, 9'd3}, {op_and, 9'h013}, {op_out, 9'd4},
	{op_orr, 9'h014}, {op_out, 9'd5}, {op_xor, 9'h015}, {op_out, 9'd6},
	{op_inn, 9'd3}, {op_out, 9'd7}, {op_inn, 9'd6}, {op_out, 9'd0},
	// Nested stack expressions at 16..31
	{op_lod, 9'h016}, {op_lod, 9'h017}, {op_lod, 9'h018}, {op_add_p, 9'd0},
	{op_sub_p, 9'd0}, {op_out, 9'd1}, {op_lod, 9'h019}, {op_psh, 9'd0},
	{op_lod, 9'h01A}, {op_sub_p, 9'd0}, {op_xor_p, 9'd0}, {op_and_p, 9'd0},
	{op_out, 9'd2}, {op_lod, 9'h01B}, {op_orr_p, 9'd0}, {op_out, 9'd3},
	// Store then reload at 32..36
	{op_set, 9'h100}, {op_xor, 9'h01C}, {op_out, 9'd4}, {op_lod, 9'h100},
	{op_out, 9'd5},
	// Countdown loop at 37..42
	{op_lod, count_addr}, {op_out, 9'd2}, {op_sub, one_addr}, {op_jiz, 9'd42},
	{op_jmp, 9'd38}, {op_out, 9'd3},
	// Two call levels and the halt at 54
	{op_cal, 9'd46}, {op_out, 9'd4}, {op_jmp, 9'd54}, {op_xor, 9'h01D},
	{op_out, 9'd5}, {op_cal, 9'd51}, {op_out, 9'd6}, {op_ret, 9'd0},
	{op_add, 9'h01E}, {op_out, 9'd7}, {op_ret, 9'd0}, {op_jmp, 9'd54}
};

function automatic string section_name(input int pc);
	if (pc < sec_stack) return "mem_alu_io";
	else if (pc < sec_store) return "stack_expr";
	else if (pc < sec_loop) return "store_reload";
	else if (pc < sec_call) return "countdown";
	else return "call_ret";
endfunction

// Walks the program up to the self-jump and fills the expected lists
// Returns the executed step count or -1 without a halt
function automatic int run_reference();
	logic [data_bits-1:0]      mem [1 << data_addr_bits];
	logic [data_bits-1:0]      dstk [$];
	logic [code_addr_bits-1:0] rstk [$];
	logic [data_bits-1:0]      acc;
	logic [code_addr_bits-1:0] pc;
	logic [code_addr_bits-1:0] next_pc;
	logic [opcode_bits-1:0]    op;
	logic [operand_bits-1:0]   opnd;
	int                        steps;
	bit                        halted;

	mem = dmem;
	acc = '0;
	pc = '0;
	steps = 0;
	halted = 1'b0;
	while (!halted && steps < step_limit) begin
		op   = prog_mem[pc][instr_bits-1:operand_bits];
		opnd = prog_mem[pc][operand_bits-1:0];
		if (op == op_jmp && opnd == pc) begin
			halted = 1'b1;
		end else begin
			steps++;
			next_pc = pc + 9'd1;
			case (op)
				op_lod: begin
					dstk.push_back(acc);
					acc = mem[opnd];
				end
				op_set: mem[opnd] = acc;
				op_add: acc = acc + mem[opnd];
				op_sub: acc = acc - mem[opnd];
				op_and: acc = acc & mem[opnd];
				op_orr: acc = acc | mem[opnd];
				op_xor: acc = acc ^ mem[opnd];
				// Popped word on the left side
				op_add_p: acc = dstk.pop_back() + acc;
				op_sub_p: acc = dstk.pop_back() - acc;
				op_and_p: acc = dstk.pop_back() & acc;
				op_orr_p: acc = dstk.pop_back() | acc;
				op_xor_p: acc = dstk.pop_back() ^ acc;
				op_jmp: next_pc = opnd;
				op_jiz: begin
					if (acc == '0) next_pc = opnd;
				end
				op_cal: begin
					rstk.push_back(pc + 9'd1);
					next_pc = opnd;
				end
				op_ret: next_pc = rstk.pop_back();
				op_inn: begin
					dstk.push_back(acc);
					acc = io_tbl[opnd[io_port_bits-1:0]];
				end
				op_out: begin
					exp_port.push_back(opnd[io_port_bits-1:0]);
					exp_data.push_back(acc);
					exp_name.push_back(section_name(int'(pc)));
				end
				op_psh: dstk.push_back(acc);
				default: ;
			endcase
			pc = next_pc;
		end
	end
	if (!halted) steps = -1;
	return steps;
endfunction

`endif

/* testbench/stack_core_tb.sv */
/*
 * Testbench for the stack core
 * Runs a fixed program on modeled memories and checks every output strobe
 */
`timescale 1ns/10ps
`default_nettype none

module stack_core_tb;

	import isa_pkg::*;

	localparam int data_bits     = 16;
	localparam int rstack_depth  = 8;
	localparam int dstack_depth  = 8;
	localparam int clk_period    = 8;
	localparam int reset_cycles  = 2;
	localparam int settle_cycles = 20;
	localparam int margin_cycles = 50;

	logic                      clk = 1'b0;
	logic                      rst;
	instr_t                    instr;
	logic [code_addr_bits-1:0] instr_addr;
	logic [data_addr_bits-1:0] mem_addr;
	logic [data_bits-1:0]      mem_data_rd;
	logic                      mem_wr;
	logic [data_bits-1:0]      mem_data_wr;
	logic [data_bits-1:0]      io_in;
	logic [io_port_bits-1:0]   in_port;
	logic                      out_en;
	logic [io_port_bits-1:0]   out_port;
	logic [data_bits-1:0]      out_data;

	// Memory and I/O models
	logic [instr_bits-1:0] prog_mem [1 << code_addr_bits];
	logic [data_bits-1:0]  dmem [1 << data_addr_bits];
	logic [data_bits-1:0]  io_tbl [1 << io_port_bits];

	// Expected outputs in order
	logic [io_port_bits-1:0] exp_port [$];
	logic [data_bits-1:0]    exp_data [$];
	string                   exp_name [$];

	integer seed      = 82930;
	int     ref_steps = 0;
	bit     ref_ready = 1'b0;
	int     out_count = 0;

	`include "stack_core_tb_ref.svh"

	stack_core #(
		.data_bits   (data_bits),
		.rstack_depth(rstack_depth),
		.dstack_depth(dstack_depth)
	) i_stack_core (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instr_addr (instr_addr),
		.mem_addr   (mem_addr),
		.mem_data_rd(mem_data_rd),
		.mem_wr     (mem_wr),
		.mem_data_wr(mem_data_wr),
		.io_in      (io_in),
		.in_port    (in_port),
		.out_en     (out_en),
		.out_port   (out_port),
		.out_data   (out_data)
	);

	always #(clk_period / 2) clk = ~clk;

	// Combinational reads and a clocked store
	assign instr       = prog_mem[instr_addr];
	assign mem_data_rd = dmem[mem_addr];
	assign io_in       = io_tbl[in_port];

	always @(posedge clk) begin
		if (!rst && mem_wr) begin
			dmem[mem_addr] <= mem_data_wr;
		end
	end

	// ------------------------------------------------------------
	// Reporting
	// ------------------------------------------------------------
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "run stopped");
	endtask

	task automatic report_mismatch(input string test, input string item,
			input logic [31:0] expected, input logic [31:0] actual);
		$display("[ERROR] %s: %s expected %h, actual %h", test, item, expected, actual);
		report_failure("Value mismatch");
	endtask

	// Program, then random data and I/O words, then loop constants
	task automatic fill_memories();
		for (int i = 0; i < (1 << code_addr_bits); i++) begin
			// Unused code traps in a self-jump
			prog_mem[i] = (i < prog_len) ? program_image[i] : {op_jmp, 9'(i)};
		end
		for (int i = 0; i < (1 << data_addr_bits); i++) begin
			dmem[i] = data_bits'($random(seed));
		end
		for (int i = 0; i < (1 << io_port_bits); i++) begin
			io_tbl[i] = data_bits'($random(seed));
		end
		dmem[one_addr]   = 16'd1;
		dmem[count_addr] = count_init;
	endtask

	task automatic check_reset_state();
		assert (instr_addr == '0) else
			report_mismatch("reset", "instr_addr", 32'd0, 32'(instr_addr));
		assert (out_en == 1'b0) else
			report_mismatch("reset", "out_en", 32'd0, 32'(out_en));
		assert (mem_wr == 1'b0) else
			report_mismatch("reset", "mem_wr", 32'd0, 32'(mem_wr));
	endtask

	// ------------------------------------------------------------
	// Checkers
	// ------------------------------------------------------------
	always @(negedge clk) begin
		if (rst) begin
			check_reset_state();
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!rst && out_en) begin
			assert (out_count < exp_port.size()) else
				report_failure("Output strobe seen after the last expected output");
			if (out_count < exp_port.size()) begin
				assert (out_port == exp_port[out_count]) else
					report_mismatch(exp_name[out_count], "port",
						32'(exp_port[out_count]), 32'(out_port));
				assert (out_data == exp_data[out_count]) else
					report_mismatch(exp_name[out_count], "value",
						32'(exp_data[out_count]), 32'(out_data));
				out_count++;
			end
		end
	end

	// Budget is one cycle per step plus reset and margin
	initial begin
		wait (ref_ready);
		#((ref_steps + reset_cycles + margin_cycles) * clk_period);
		report_failure("Timeout, the program did not finish in time");
	end

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin
		rst = 1'b1;
		fill_memories();
		ref_steps = run_reference();
		assert (ref_steps > 0) else
			report_failure("Reference interpreter never reached the halt loop");
		ref_ready = 1'b1;
		#1;
		check_reset_state();
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
		wait (out_count == exp_port.size());
		// Quiet period catches any extra strobe
		repeat (settle_cycles) @(posedge clk);
		@(negedge clk);
		assert (instr_addr == code_addr_bits'(halt_addr)) else
			report_mismatch("halt", "instr_addr", 32'(halt_addr), 32'(instr_addr));
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire
